// ==== adam_ctrl.f ====
+incdir+common
common/adam_ctrl_pkg.sv
common/keypad_emu_if.sv
common/ctrl_port_if.sv
hw/ps2_keypad_emu.sv
hw/pad_router.sv
hw/ctrl_port.sv
hw/adam_ctrl_top.sv
verif/tb_adam_ctrl.sv

// ==== Bender.yml ====
package:
  name: adam_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/adam_ctrl_pkg.sv
      - common/keypad_emu_if.sv
      - common/ctrl_port_if.sv
      - hw/ps2_keypad_emu.sv
      - hw/pad_router.sv
      - hw/ctrl_port.sv
      - hw/adam_ctrl_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_adam_ctrl.sv

// ==== verif/tb_adam_ctrl.sv ====
//====================
// Adam controller testbench
// Checks reset, keypad and joystick strobes, player swap and the
// PS/2 keypad emulation against a reference model
//====================

`timescale 1ns/1ps
`include "adam_ctrl_cfg.svh"

module tb_adam_ctrl;
        import adam_ctrl_pkg::*;

        localparam time CLK_PERIOD = 100;
        // Reset, keypad, joystick, swap and keyboard tests
        localparam int  TEST_CYCLES = 14 + 40 + 40 + 20 + 40;

        logic           clk_sys = 1'b0;
        logic           rst_i = 1'b1;
        joy_word_t      joy0_i = '0;
        joy_word_t      joy1_i = '0;
        logic           swap_i = 1'b0;
        ps2_key_t       ps2_key_i = '0;
        logic [1:0]     sel_keypad_n_i = 2'b11;
        logic [1:0]     sel_joy_n_i = 2'b11;
        ctrl_nib_t      ctrl_data0_o;
        ctrl_nib_t      ctrl_data1_o;
        logic [1:0]     ctrl_fire_n_o;

        integer         seed = 18136;
        int             pass_cnt = 0;
        int             fail_cnt = 0;
        logic           key_tog = 1'b0;

        // Reference keyboard state
        logic [9:0]     kb_digit = '0;
        logic           kb_star = 1'b0;
        logic           kb_shift = 1'b0;
        logic           kb_minus = 1'b0;

        logic [7:0]     main_sc [10] = '{`ADAM_SC_0, `ADAM_SC_1, `ADAM_SC_2, `ADAM_SC_3,
                `ADAM_SC_4, `ADAM_SC_5, `ADAM_SC_6, `ADAM_SC_7, `ADAM_SC_8, `ADAM_SC_9};
        logic [7:0]     pad_sc [10] = '{`ADAM_SC_KP_0, `ADAM_SC_KP_1, `ADAM_SC_KP_2,
                `ADAM_SC_KP_3, `ADAM_SC_KP_4, `ADAM_SC_KP_5, `ADAM_SC_KP_6,
                `ADAM_SC_KP_7, `ADAM_SC_KP_8, `ADAM_SC_KP_9};

        adam_ctrl_top UUT (
                .clk_sys        (clk_sys),
                .rst_i          (rst_i),
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .swap_i         (swap_i),
                .ps2_key_i      (ps2_key_i),
                .sel_keypad_n_i (sel_keypad_n_i),
                .sel_joy_n_i    (sel_joy_n_i),
                .ctrl_data0_o   (ctrl_data0_o),
                .ctrl_data1_o   (ctrl_data1_o),
                .ctrl_fire_n_o  (ctrl_fire_n_o)
        );

        always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

        // Idle strobes always return all ones
        assert property (@(posedge clk_sys) disable iff (rst_i)
                (sel_keypad_n_i[0] && sel_joy_n_i[0])
                |-> (ctrl_data0_o == 4'hF && ctrl_fire_n_o[0]))
        else begin
                fail_cnt++;
                $display("[FAIL] %0t: port 0 not idle with both strobes high", $time);
        end

        assert property (@(posedge clk_sys) disable iff (rst_i)
                (sel_keypad_n_i[1] && sel_joy_n_i[1])
                |-> (ctrl_data1_o == 4'hF && ctrl_fire_n_o[1]))
        else begin
                fail_cnt++;
                $display("[FAIL] %0t: port 1 not idle with both strobes high", $time);
        end

        //====================
        // Reference model
        //====================

        function automatic ctrl_nib_t key_code(input int idx);
                case (idx)
                0: return `ADAM_KEY_0;
                1: return `ADAM_KEY_1;
                2: return `ADAM_KEY_2;
                3: return `ADAM_KEY_3;
                4: return `ADAM_KEY_4;
                5: return `ADAM_KEY_5;
                6: return `ADAM_KEY_6;
                7: return `ADAM_KEY_7;
                8: return `ADAM_KEY_8;
                9: return `ADAM_KEY_9;
                10: return `ADAM_KEY_STAR;
                11: return `ADAM_KEY_NUMBER;
                12: return `ADAM_KEY_PT;
                default: return `ADAM_KEY_BT;
                endcase
        endfunction

        function automatic pad_vec_t model_pad(input int port);
                joy_word_t j;
                pad_vec_t pad;
                if (port == 0) begin
                        j = swap_i ? joy1_i : joy0_i;
                end else begin
                        j = swap_i ? joy0_i : joy1_i;
                end
                // Fire2 fire1 right left down up blue purple number star digits
                pad = {j[5], j[4], j[0], j[1], j[2], j[3], j[19], j[18], j[7], j[6], j[17:8]};
                pad[9:0] = pad[9:0] | kb_digit;
                pad[10] = pad[10] | kb_star | (kb_shift & kb_digit[8]);
                pad[11] = pad[11] | kb_minus | (kb_shift & kb_digit[3]);
                return pad;
        endfunction

        function automatic ctrl_nib_t model_data(input pad_vec_t pad, input logic skn,
                                                 input logic sjn);
                ctrl_nib_t kp;
                ctrl_nib_t jy;
                kp = `ADAM_KEY_NONE;
                for (int i = 13; i >= 0; i--) begin
                        if (pad[i]) begin
                                kp = key_code(i);
                        end
                end
                if (skn) begin
                        kp = 4'b1111;
                end
                jy = sjn ? 4'b1111 : ~{pad[14], pad[15], pad[16], pad[17]};
                return kp & jy;
        endfunction

        task automatic apply_key(input logic [7:0] code, input logic press);
                if (code == `ADAM_SC_KP_STAR) begin
                        kb_star = press;
                end else if (code == `ADAM_SC_LSHIFT || code == `ADAM_SC_RSHIFT) begin
                        kb_shift = press;
                end else if (code == `ADAM_SC_KP_MINUS) begin
                        kb_minus = press;
                end
                for (int d = 0; d < 10; d++) begin
                        if (code == main_sc[d] || code == pad_sc[d]) begin
                                kb_digit[d] = press;
                        end
                end
        endtask

        //====================
        // Checks and stimulus
        //====================

        task automatic check_ports(input string tag);
                pad_vec_t pad;
                ctrl_nib_t got;
                ctrl_nib_t exp_nib;
                logic exp_fire;
                for (int p = 0; p < 2; p++) begin
                        pad = model_pad(p);
                        got = (p == 0) ? ctrl_data0_o : ctrl_data1_o;
                        exp_nib = model_data(pad, sel_keypad_n_i[p], sel_joy_n_i[p]);
                        exp_fire = (sel_keypad_n_i[p] | ~pad[19]) & (sel_joy_n_i[p] | ~pad[18]);
                        assert (got == exp_nib && ctrl_fire_n_o[p] == exp_fire) begin
                                pass_cnt++;
                        end else begin
                                fail_cnt++;
                                $display("[FAIL] %0t: %s port %0d data %b fire %b, expected %b %b",
                                         $time, tag, p, got, ctrl_fire_n_o[p], exp_nib, exp_fire);
                        end
                end
        endtask

        task automatic drive_edge();
                @(posedge clk_sys);
                #10;
        endtask

        // Random words, every other one thinned out to reach the rarer keys
        function automatic joy_word_t random_joy(input int i);
                joy_word_t j;
                j = joy_word_t'($random(seed));
                if (i % 2 == 1) begin
                        j = j & joy_word_t'($random(seed) & $random(seed) & $random(seed));
                end
                return (i == 0) ? '0 : j;
        endfunction

        task automatic random_step(input string tag, input int i, input logic swap_en,
                                   input logic [1:0] skn, input logic [1:0] sjn);
                drive_edge();
                swap_i = swap_en;
                sel_keypad_n_i = skn;
                sel_joy_n_i = sjn;
                joy0_i = random_joy(i);
                joy1_i = random_joy(i + 1);
                @(negedge clk_sys);
                check_ports(tag);
        endtask

        task automatic send_key(input logic [7:0] code, input logic press, input logic ext,
                                input logic fresh);
                if (fresh) begin
                        key_tog = ~key_tog;
                end
                drive_edge();
                ps2_key_i = {key_tog, press, ext, code};
                @(negedge clk_sys);
                check_ports("key before edge");
                @(posedge clk_sys);
                if (fresh) begin
                        apply_key(code, press);
                end
                @(negedge clk_sys);
                check_ports("key after edge");
        endtask

        task automatic report_test(input string name, input int fails_before);
                if (fail_cnt == fails_before) begin
                        $display("%s: pass", name);
                end else begin
                        $display("%s: %0d failing checks", name, fail_cnt - fails_before);
                end
        endtask

        initial begin
                #(TEST_CYCLES * 2 * CLK_PERIOD);
                $display("Watchdog expired, the tests did not finish in time");
                $display("TEST FAILED");
                $finish;
        end

        initial begin
                int fails;

                repeat (8) @(posedge clk_sys);
                #10;
                rst_i = 1'b0;
                fails = fail_cnt;
                @(negedge clk_sys);
                check_ports("reset");
                // Idle strobes hide whatever the joysticks hold
                for (int i = 1; i < 5; i++) begin
                        random_step("idle", i, 1'b0, 2'b11, 2'b11);
                end
                report_test("reset state", fails);

                fails = fail_cnt;
                for (int i = 0; i < 40; i++) begin
                        random_step("keypad", i, 1'b0, 2'b00, 2'b11);
                end
                report_test("keypad priority", fails);

                fails = fail_cnt;
                for (int i = 0; i < 40; i++) begin
                        random_step("joystick", i, 1'b0, (i < 20) ? 2'b11 : 2'b00, 2'b00);
                end
                report_test("joystick select", fails);

                fails = fail_cnt;
                for (int i = 0; i < 20; i++) begin
                        random_step("swap", i + 1, 1'b1, 2'b01, 2'b10);
                end
                report_test("player swap", fails);

                // Joysticks quiet so only the keyboard shows
                fails = fail_cnt;
                drive_edge();
                swap_i = 1'b0;
                joy0_i = '0;
                joy1_i = '0;
                sel_keypad_n_i = 2'b00;
                sel_joy_n_i = 2'b11;
                send_key(`ADAM_SC_5, 1'b1, 1'b0, 1'b1);
                send_key(`ADAM_SC_5, 1'b0, 1'b0, 1'b1);
                send_key(`ADAM_SC_KP_7, 1'b1, 1'b1, 1'b1);
                send_key(`ADAM_SC_KP_7, 1'b0, 1'b1, 1'b1);
                send_key(`ADAM_SC_KP_STAR, 1'b1, 1'b0, 1'b1);
                send_key(`ADAM_SC_KP_STAR, 1'b0, 1'b0, 1'b1);
                send_key(`ADAM_SC_LSHIFT, 1'b1, 1'b0, 1'b1);
                send_key(`ADAM_SC_8, 1'b1, 1'b0, 1'b1);
                send_key(`ADAM_SC_8, 1'b0, 1'b0, 1'b1);
                send_key(`ADAM_SC_3, 1'b1, 1'b0, 1'b1);
                send_key(`ADAM_SC_3, 1'b0, 1'b0, 1'b1);
                send_key(`ADAM_SC_LSHIFT, 1'b0, 1'b0, 1'b1);
                send_key(`ADAM_SC_KP_MINUS, 1'b1, 1'b0, 1'b1);
                send_key(`ADAM_SC_KP_MINUS, 1'b0, 1'b0, 1'b1);
                // Same toggle as before, must be ignored
                send_key(`ADAM_SC_1, 1'b1, 1'b0, 1'b0);
                report_test("keyboard emulation", fails);

                $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

// ==== hw/adam_ctrl_top.sv ====
//====================
// Adam controller section
// PS/2 keypad emulation, pad routing and the two controller ports
//====================

`timescale 1ns/1ps
`include "adam_ctrl_cfg.svh"

module adam_ctrl_top (
        input  logic                            clk_sys,
        input  logic                            rst_i,
        input  adam_ctrl_pkg::joy_word_t        joy0_i,
        input  adam_ctrl_pkg::joy_word_t        joy1_i,
        input  logic                            swap_i,
        input  adam_ctrl_pkg::ps2_key_t         ps2_key_i,
        input  logic [`ADAM_NUM_PLAYERS-1:0]    sel_keypad_n_i,
        input  logic [`ADAM_NUM_PLAYERS-1:0]    sel_joy_n_i,
        output adam_ctrl_pkg::ctrl_nib_t        ctrl_data0_o,
        output adam_ctrl_pkg::ctrl_nib_t        ctrl_data1_o,
        output logic [`ADAM_NUM_PLAYERS-1:0]    ctrl_fire_n_o
);
        import adam_ctrl_pkg::*;

        pad_vec_t       pads [`ADAM_NUM_PLAYERS];
        ctrl_nib_t      data_n [`ADAM_NUM_PLAYERS];

        keypad_emu_if   emu_bus ();
        ctrl_port_if    port_bus [`ADAM_NUM_PLAYERS] ();

        //====================
        // Keyboard and routing
        //====================

        ps2_keypad_emu u_keypad_emu (
                .clk_sys        (clk_sys),
                .rst_i          (rst_i),
                .ps2_key_i      (ps2_key_i),
                .emu_o          (emu_bus.decoder)
        );

        pad_router u_pad_router (
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .swap_i         (swap_i),
                .emu_i          (emu_bus.router),
                .pad0_o         (pads[0]),
                .pad1_o         (pads[1])
        );

        //====================
        // Controller ports
        //====================

        for (genvar g = 0; g < `ADAM_NUM_PLAYERS; g++) begin : g_port
                assign port_bus[g].sel_keypad_n = sel_keypad_n_i[g];
                assign port_bus[g].sel_joy_n    = sel_joy_n_i[g];

                ctrl_port u_ctrl_port (
                        .pad_i          (pads[g]),
                        .port_o         (port_bus[g].port)
                );

                assign data_n[g]        = port_bus[g].data_n;
                assign ctrl_fire_n_o[g] = port_bus[g].fire_n;
        end

        assign ctrl_data0_o = data_n[0];
        assign ctrl_data1_o = data_n[1];

endmodule

// ==== hw/ctrl_port.sv ====
//====================
// Controller port
// Returns the keypad or joystick nibble and the fire line
// selected by the console strobes
//====================

`timescale 1ns/1ps
`include "adam_ctrl_cfg.svh"

module ctrl_port (
        input  adam_ctrl_pkg::pad_vec_t pad_i,
        ctrl_port_if.port               port_o
);
        import adam_ctrl_pkg::*;

        // Console code for each of pad positions 0..13
        localparam ctrl_nib_t key_lut [`ADAM_PAD_BLUE + 1] = '{
                `ADAM_KEY_0,
                `ADAM_KEY_1,
                `ADAM_KEY_2,
                `ADAM_KEY_3,
                `ADAM_KEY_4,
                `ADAM_KEY_5,
                `ADAM_KEY_6,
                `ADAM_KEY_7,
                `ADAM_KEY_8,
                `ADAM_KEY_9,
                `ADAM_KEY_STAR,
                `ADAM_KEY_NUMBER,
                `ADAM_KEY_PT,
                `ADAM_KEY_BT
        };

        ctrl_nib_t      kp_code;
        ctrl_nib_t      kp_nib;
        ctrl_nib_t      joy_nib;
        logic           kp_fire;
        logic           joy_fire;

        //====================
        // Keypad half
        //====================

        // Walk down so the lowest set position wins
        always_comb begin
                kp_code = `ADAM_KEY_NONE;
                for (int b = `ADAM_PAD_BLUE; b >= `ADAM_PAD_DIGIT0; b--) begin
                        if (pad_i[b]) begin
                                kp_code = key_lut[b];
                        end
                end
        end

        assign kp_nib  = port_o.sel_keypad_n ? `ADAM_KEY_NONE : kp_code;
        assign kp_fire = port_o.sel_keypad_n | ~pad_i[`ADAM_PAD_FIRE2];

        //====================
        // Joystick half
        //====================

        // Up on the MSB, right on the LSB
        assign joy_nib  = port_o.sel_joy_n ? `ADAM_KEY_NONE :
                          ~{pad_i[`ADAM_PAD_UP], pad_i[`ADAM_PAD_DOWN],
                            pad_i[`ADAM_PAD_LEFT], pad_i[`ADAM_PAD_RIGHT]};
        assign joy_fire = port_o.sel_joy_n | ~pad_i[`ADAM_PAD_FIRE1];

        // Both strobes low merge as wired AND
        assign port_o.data_n = kp_nib & joy_nib;
        assign port_o.fire_n = kp_fire & joy_fire;

endmodule

// ==== hw/pad_router.sv ====
//====================
// Pad router
// Player swap, joystick to pad reordering and keyboard merge
//====================

`timescale 1ns/1ps
`include "adam_ctrl_cfg.svh"

module pad_router (
        input  adam_ctrl_pkg::joy_word_t joy0_i,
        input  adam_ctrl_pkg::joy_word_t joy1_i,
        input  logic                     swap_i,
        keypad_emu_if.router             emu_i,
        output adam_ctrl_pkg::pad_vec_t  pad0_o,
        output adam_ctrl_pkg::pad_vec_t  pad1_o
);
        import adam_ctrl_pkg::*;

        joy_word_t      joy_a;
        joy_word_t      joy_b;
        pad_vec_t       kbd_pad;

        // Host joystick layout into console pad order
        function automatic pad_vec_t joy_to_pad(input joy_word_t joy);
                pad_vec_t pad;
                pad = '0;
                for (int d = 0; d < `ADAM_NUM_DIGITS; d++) begin
                        pad[`ADAM_PAD_DIGIT0 + d] = joy[`ADAM_JOY_DIGIT0 + d];
                end
                pad[`ADAM_PAD_STAR]   = joy[`ADAM_JOY_STAR];
                pad[`ADAM_PAD_NUMBER] = joy[`ADAM_JOY_NUMBER];
                pad[`ADAM_PAD_PURPLE] = joy[`ADAM_JOY_PURPLE];
                pad[`ADAM_PAD_BLUE]   = joy[`ADAM_JOY_BLUE];
                pad[`ADAM_PAD_UP]     = joy[`ADAM_JOY_UP];
                pad[`ADAM_PAD_DOWN]   = joy[`ADAM_JOY_DOWN];
                pad[`ADAM_PAD_LEFT]   = joy[`ADAM_JOY_LEFT];
                pad[`ADAM_PAD_RIGHT]  = joy[`ADAM_JOY_RIGHT];
                pad[`ADAM_PAD_FIRE1]  = joy[`ADAM_JOY_FIRE1];
                pad[`ADAM_PAD_FIRE2]  = joy[`ADAM_JOY_FIRE2];
                return pad;
        endfunction

        assign joy_a = swap_i ? joy1_i : joy0_i;
        assign joy_b = swap_i ? joy0_i : joy1_i;

        // Keyboard buttons, shared by both players
        always_comb begin
                kbd_pad = '0;
                for (int d = 0; d < `ADAM_NUM_DIGITS; d++) begin
                        kbd_pad[`ADAM_PAD_DIGIT0 + d] = emu_i.digit[d];
                end
                // Shift+8 is '*' and shift+3 is '#' on a PC keyboard
                kbd_pad[`ADAM_PAD_STAR]   = emu_i.star | (emu_i.shift & emu_i.digit[8]);
                kbd_pad[`ADAM_PAD_NUMBER] = emu_i.minus | (emu_i.shift & emu_i.digit[3]);
        end

        assign pad0_o = joy_to_pad(joy_a) | kbd_pad;
        assign pad1_o = joy_to_pad(joy_b) | kbd_pad;

endmodule

// ==== hw/ps2_keypad_emu.sv ====
//====================
// PS/2 keypad emulation
// Watches the PS/2 event word and keeps the held state of the keys
// that stand in for the numeric keypad
//====================

`timescale 1ns/1ps
`include "adam_ctrl_cfg.svh"

module ps2_keypad_emu (
        input  logic                    clk_sys,
        input  logic                    rst_i,
        input  adam_ctrl_pkg::ps2_key_t ps2_key_i,
        keypad_emu_if.decoder           emu_o
);
        import adam_ctrl_pkg::*;

        logic           toggle_q;
        logic           new_event;
        logic           pressed;
        logic [7:0]     code;

        digit_vec_t     digit_q;
        logic           star_q;
        logic           shift_q;
        logic           minus_q;

        // A new event flips the toggle bit
        assign new_event = toggle_q != ps2_key_i[`ADAM_PS2_TOGGLE];
        assign pressed   = ps2_key_i[`ADAM_PS2_PRESS];

        // Extended flag ignored, only the low code byte matters
        assign code      = ps2_key_i[7:0];

        always_ff @(posedge clk_sys) begin
                if (rst_i) begin
                        toggle_q <= 1'b0;
                        digit_q  <= '0;
                        star_q   <= 1'b0;
                        shift_q  <= 1'b0;
                        minus_q  <= 1'b0;
                end else begin
                        toggle_q <= ps2_key_i[`ADAM_PS2_TOGGLE];
                        if (new_event) begin
                                case (code)
                                `ADAM_SC_0, `ADAM_SC_KP_0: digit_q[0] <= pressed;
                                `ADAM_SC_1, `ADAM_SC_KP_1: digit_q[1] <= pressed;
                                `ADAM_SC_2, `ADAM_SC_KP_2: digit_q[2] <= pressed;
                                `ADAM_SC_3, `ADAM_SC_KP_3: digit_q[3] <= pressed;
                                `ADAM_SC_4, `ADAM_SC_KP_4: digit_q[4] <= pressed;
                                `ADAM_SC_5, `ADAM_SC_KP_5: digit_q[5] <= pressed;
                                `ADAM_SC_6, `ADAM_SC_KP_6: digit_q[6] <= pressed;
                                `ADAM_SC_7, `ADAM_SC_KP_7: digit_q[7] <= pressed;
                                `ADAM_SC_8, `ADAM_SC_KP_8: digit_q[8] <= pressed;
                                `ADAM_SC_9, `ADAM_SC_KP_9: digit_q[9] <= pressed;
                                `ADAM_SC_KP_STAR:          star_q     <= pressed;
                                // Either shift key drives the one level
                                `ADAM_SC_LSHIFT,
                                `ADAM_SC_RSHIFT:           shift_q    <= pressed;
                                `ADAM_SC_KP_MINUS:         minus_q    <= pressed;
                                default: begin
                                        // Other keys leave the buttons alone
                                end
                                endcase
                        end
                end
        end

        assign emu_o.digit = digit_q;
        assign emu_o.star  = star_q;
        assign emu_o.shift = shift_q;
        assign emu_o.minus = minus_q;

endmodule

// ==== common/ctrl_port_if.sv ====
//====================
// Controller port bus
// Strobes into one port and the lines it returns
//====================

`timescale 1ns/1ps

interface ctrl_port_if;
        import adam_ctrl_pkg::*;

        // Strobes, active low (P5 keypad, P8 joystick)
        logic           sel_keypad_n;
        logic           sel_joy_n;

        // Returned lines, P1..P4 and P6
        ctrl_nib_t      data_n;
        logic           fire_n;

        modport port (
                input   sel_keypad_n,
                input   sel_joy_n,
                output  data_n,
                output  fire_n
        );

        modport pins (
                output  sel_keypad_n,
                output  sel_joy_n,
                input   data_n,
                input   fire_n
        );

endinterface

// ==== common/keypad_emu_if.sv ====
//====================
// Keypad emulation bus
// Held button levels from the PS/2 decoder to the pad router
//====================

`timescale 1ns/1ps

interface keypad_emu_if;
        import adam_ctrl_pkg::*;

        // Registered levels, high while the key is held
        digit_vec_t     digit;
        logic           star;
        logic           shift;
        logic           minus;

        modport decoder (
                output  digit,
                output  star,
                output  shift,
                output  minus
        );

        modport router (
                input   digit,
                input   star,
                input   shift,
                input   minus
        );

endinterface

// ==== common/adam_ctrl_pkg.sv ====
//====================
// Adam controller types
// Vector types shared by the controller RTL and its testbench
//====================

`include "adam_ctrl_cfg.svh"

package adam_ctrl_pkg;

        // One player's joystick word as delivered by the host
        typedef logic [`ADAM_JOY_BITS-1:0] joy_word_t;

        // Buttons in console order, see ADAM_PAD_* positions
        typedef logic [`ADAM_PAD_BITS-1:0] pad_vec_t;

        // PS/2 event word
        // [10] toggles per event, [9] press, [8] extended, [7:0] code
        typedef logic [`ADAM_PS2_BITS-1:0] ps2_key_t;

        // Data nibble on P1..P4, active low
        typedef logic [`ADAM_NIB_BITS-1:0] ctrl_nib_t;

        // Emulated digit buttons 0..9
        typedef logic [`ADAM_NUM_DIGITS-1:0] digit_vec_t;

endpackage

// ==== common/adam_ctrl_cfg.svh ====
//====================
// Adam controller configuration
// Widths, pad bit positions, console keypad codes and the PS/2 scancodes
// used by the keypad emulation
//====================

`ifndef ADAM_CTRL_CFG_SVH
`define ADAM_CTRL_CFG_SVH

// Sizes
`define ADAM_NUM_PLAYERS        2
`define ADAM_PAD_BITS           20
`define ADAM_JOY_BITS           20
`define ADAM_PS2_BITS           11
`define ADAM_NIB_BITS           4
`define ADAM_NUM_DIGITS         10

// PS/2 event word fields
`define ADAM_PS2_TOGGLE         10
`define ADAM_PS2_PRESS          9

//====================
// Pad vector, console order
//====================
`define ADAM_PAD_DIGIT0         0
`define ADAM_PAD_STAR           10
`define ADAM_PAD_NUMBER         11
`define ADAM_PAD_PURPLE         12
`define ADAM_PAD_BLUE           13
`define ADAM_PAD_UP             14
`define ADAM_PAD_DOWN           15
`define ADAM_PAD_LEFT           16
`define ADAM_PAD_RIGHT          17
`define ADAM_PAD_FIRE1          18
`define ADAM_PAD_FIRE2          19

//====================
// Joystick word from the host
//====================
`define ADAM_JOY_RIGHT          0
`define ADAM_JOY_LEFT           1
`define ADAM_JOY_DOWN           2
`define ADAM_JOY_UP             3
`define ADAM_JOY_FIRE1          4
`define ADAM_JOY_FIRE2          5
`define ADAM_JOY_STAR           6
`define ADAM_JOY_NUMBER         7
`define ADAM_JOY_DIGIT0         8
`define ADAM_JOY_PURPLE         18
`define ADAM_JOY_BLUE           19

//====================
// Keypad nibbles on P1..P4
//====================
`define ADAM_KEY_0              4'b0011
`define ADAM_KEY_1              4'b1110
`define ADAM_KEY_2              4'b1101
`define ADAM_KEY_3              4'b0110
`define ADAM_KEY_4              4'b0001
`define ADAM_KEY_5              4'b1001
`define ADAM_KEY_6              4'b0111
`define ADAM_KEY_7              4'b1100
`define ADAM_KEY_8              4'b1000
`define ADAM_KEY_9              4'b1011
`define ADAM_KEY_STAR           4'b1010
`define ADAM_KEY_NUMBER         4'b0101
`define ADAM_KEY_PT             4'b0100
`define ADAM_KEY_BT             4'b0010
`define ADAM_KEY_NONE           4'b1111

// PS/2 set 2, main row digits
`define ADAM_SC_0               8'h45
`define ADAM_SC_1               8'h16
`define ADAM_SC_2               8'h1E
`define ADAM_SC_3               8'h26
`define ADAM_SC_4               8'h25
`define ADAM_SC_5               8'h2E
`define ADAM_SC_6               8'h36
`define ADAM_SC_7               8'h3D
`define ADAM_SC_8               8'h3E
`define ADAM_SC_9               8'h46

// Numpad digits
`define ADAM_SC_KP_0            8'h70
`define ADAM_SC_KP_1            8'h69
`define ADAM_SC_KP_2            8'h72
`define ADAM_SC_KP_3            8'h7A
`define ADAM_SC_KP_4            8'h6B
`define ADAM_SC_KP_5            8'h73
`define ADAM_SC_KP_6            8'h74
`define ADAM_SC_KP_7            8'h6C
`define ADAM_SC_KP_8            8'h75
`define ADAM_SC_KP_9            8'h7D

// Keypad star, shifts, keypad minus
`define ADAM_SC_KP_STAR         8'h7C
`define ADAM_SC_LSHIFT          8'h12
`define ADAM_SC_RSHIFT          8'h59
`define ADAM_SC_KP_MINUS        8'h7B

`endif
